// ==== f8_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "f8_defines.svh"

module f8_alu
	import f8_pkg::*;
(
	input f8_alu_op_t op,
	input f8_word_t a,
	input f8_word_t b,
	output f8_word_t result,
	output f8_flags_t flags_out
);
	logic [8:0] byte_sum;
	logic [8:0] byte_diff;
	logic [`F8_WORD_W:0] word_inc;
	logic carry;
	logic is_word;

	assign byte_sum = {1'b0, a[7:0]} + {1'b0, b[7:0]};
	// bit 8 is the borrow
	assign byte_diff = {1'b0, a[7:0]} - {1'b0, b[7:0]};
	assign word_inc = {1'b0, a} + (`F8_WORD_W+1)'(1);
	assign is_word = (op == ALU_PASS_W) || (op == ALU_INCW);

	always_comb
	begin
		carry = 1'b0;
		case (op)
			ALU_PASS_B: result = {8'h00, b[7:0]};
			ALU_PASS_W: result = b;
			ALU_ADD:
			begin
				result = {8'h00, byte_sum[7:0]};
				carry = byte_sum[8];
			end
			ALU_SUB:
			begin
				result = {8'h00, byte_diff[7:0]};
				carry = byte_diff[8];
			end
			ALU_AND: result = {8'h00, a[7:0] & b[7:0]};
			ALU_OR: result = {8'h00, a[7:0] | b[7:0]};
			ALU_XOR: result = {8'h00, a[7:0] ^ b[7:0]};
			ALU_INCW:
			begin
				result = word_inc[`F8_WORD_W-1:0];
				carry = word_inc[`F8_WORD_W];
			end
			default: result = b;
		endcase
	end

	assign flags_out = '{
		c: carry,
		z: is_word ? (result == '0) : (result[7:0] == 8'h00),
		n: is_word ? result[`F8_WORD_W-1] : result[7]
	};
endmodule

`default_nettype wire

// ==== f8_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "f8_defines.svh"

module f8_asserts
	import f8_pkg::*;
(
	input logic clk,
	input logic reset,
	input f8_word_t iread_addr,
	input f8_bytesel_t dwrite_en,
	input logic trap
);
	quiet_in_reset: assert property (@(posedge clk) reset |-> (dwrite_en == 2'b00 && !trap))
		else $error("write or trap during reset");

	// last reset cycle fetches the reset address
	fetch_reset_pc: assert property (@(posedge clk) $fell(reset) |-> $past(iread_addr) == `F8_RESET_PC)
		else $error("first fetch not at reset address");

	single_trap: assert property (@(posedge clk) disable iff (reset) trap |=> !trap)
		else $error("trap held for two cycles");
endmodule

bind f8_core f8_asserts i_asserts (
	.clk(clk),
	.reset(reset),
	.iread_addr(iread_addr),
	.dwrite_en(dwrite_en),
	.trap(trap)
);

`default_nettype wire

// ==== f8_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module f8_core
	import f8_pkg::*;
(
	input logic clk,
	input logic reset,
	input f8_inst_t iread_data,
	input f8_word_t dread_data,
	output f8_word_t iread_addr,
	output f8_word_t dread_addr,
	output f8_word_t dwrite_addr,
	output f8_word_t dwrite_data,
	output f8_bytesel_t dwrite_en,
	output logic trap
);
	f8_inst_t inst;
	f8_flags_t next_flags;

	f8_regfile_if rf_if ();

	f8_regfile i_regfile (
		.clk(clk),
		.rf(rf_if)
	);

	// decodes one instruction ahead of execute
	f8_fetch_stage i_fetch (
		.clk(clk),
		.reset(reset),
		.iread_data(iread_data),
		.next_flags(next_flags),
		.rf(rf_if),
		.iread_addr(iread_addr),
		.dread_addr(dread_addr),
		.inst(inst)
	);

	f8_execute_stage i_execute (
		.clk(clk),
		.reset(reset),
		.inst(inst),
		.dread_data(dread_data),
		.rf(rf_if),
		.next_flags(next_flags),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en),
		.trap(trap)
	);
endmodule

`default_nettype wire

// ==== f8_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module f8_decoder
	import f8_pkg::*;
(
	input f8_opcode_t opcode,
	output f8_ctrl_t ctrl
);
	localparam f8_flags_t FL_CZN = '{c: 1'b1, z: 1'b1, n: 1'b1};
	localparam f8_flags_t FL_ZN = '{c: 1'b0, z: 1'b1, n: 1'b1};

	always_comb
	begin
		ctrl = '{alu_op: ALU_PASS_B, b_src: B_IMM8, rf_sel: REG_X, rf_en: 2'b00,
			mem_en: 2'b00, flag_mask: '0, trap: 1'b0};
		case (opcode)
			OP_LD_XL_IMM:
				ctrl.rf_en = 2'b01;
			OP_LDW_Y_IMM:
			begin
				ctrl.alu_op = ALU_PASS_W;
				ctrl.b_src = B_IMM16;
				ctrl.rf_sel = REG_Y;
				ctrl.rf_en = 2'b11;
			end
			OP_ADD_XL_IMM, OP_SUB_XL_IMM:
			begin
				ctrl.alu_op = (opcode == OP_ADD_XL_IMM) ? ALU_ADD : ALU_SUB;
				ctrl.rf_en = 2'b01;
				ctrl.flag_mask = FL_CZN;
			end
			OP_AND_XL_IMM:
			begin
				ctrl.alu_op = ALU_AND;
				ctrl.rf_en = 2'b01;
				ctrl.flag_mask = FL_ZN;
			end
			OP_OR_XL_IMM:
			begin
				ctrl.alu_op = ALU_OR;
				ctrl.rf_en = 2'b01;
				ctrl.flag_mask = FL_ZN;
			end
			OP_XOR_XL_IMM:
			begin
				ctrl.alu_op = ALU_XOR;
				ctrl.rf_en = 2'b01;
				ctrl.flag_mask = FL_ZN;
			end
			OP_ADD_XL_DIR:
			begin
				ctrl.alu_op = ALU_ADD;
				ctrl.b_src = B_DATA8;
				ctrl.rf_en = 2'b01;
				ctrl.flag_mask = FL_CZN;
			end
			// stores pass the register through to dwrite_data
			OP_LD_DIR_XL:
				ctrl.mem_en = 2'b01;
			OP_LDW_DIR_Y:
			begin
				ctrl.alu_op = ALU_PASS_W;
				ctrl.mem_en = 2'b11;
			end
			OP_LDW_Y_DIR:
			begin
				ctrl.alu_op = ALU_PASS_W;
				ctrl.b_src = B_DATA16;
				ctrl.rf_sel = REG_Y;
				ctrl.rf_en = 2'b11;
			end
			OP_INCW_Y:
			begin
				ctrl.alu_op = ALU_INCW;
				ctrl.rf_sel = REG_Y;
				ctrl.rf_en = 2'b11;
				ctrl.flag_mask = FL_CZN;
			end
			OP_TRAP:
				ctrl.trap = 1'b1;
			// nop, jumps and unknown codes write nothing
			default: ;
		endcase
	end
endmodule

`default_nettype wire

// ==== f8_defines.svh ====
`ifndef F8_DEFINES_SVH
`define F8_DEFINES_SVH

// data and address width
`define F8_WORD_W 16
// opcode byte plus two operand bytes
`define F8_INST_W 24
// instructions are at most 3 bytes
`define F8_LEN_W 2

`define F8_RESET_PC 16'h4000

`endif

// ==== f8_execute_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module f8_execute_stage
	import f8_pkg::*;
(
	input logic clk,
	input logic reset,
	input f8_inst_t inst,
	input f8_word_t dread_data,
	f8_regfile_if.exec rf,
	output f8_flags_t next_flags,
	output f8_word_t dwrite_addr,
	output f8_word_t dwrite_data,
	output f8_bytesel_t dwrite_en,
	output logic trap
);
	f8_ctrl_t ctrl;
	f8_flags_t flags;
	f8_flags_t alu_flags;
	f8_word_t opnd_a;
	f8_word_t opnd_b;
	f8_word_t src_b;
	f8_word_t result;

	f8_decoder i_decoder (
		.opcode(inst.opcode),
		.ctrl(ctrl)
	);

	// word ops act on y, byte ops on xl
	assign opnd_a = (ctrl.alu_op == ALU_PASS_W || ctrl.alu_op == ALU_INCW)
		? rf.y : {8'h00, rf.x[7:0]};

	always_comb
	begin
		case (ctrl.b_src)
			B_IMM8: src_b = {8'h00, inst.operand[7:0]};
			B_IMM16: src_b = inst.operand;
			B_DATA8: src_b = {8'h00, dread_data[7:0]};
			default: src_b = dread_data;
		endcase
	end

	// a store sends its source register down the pass path
	assign opnd_b = (ctrl.mem_en != 2'b00) ? opnd_a : src_b;

	f8_alu i_alu (
		.op(ctrl.alu_op),
		.a(opnd_a),
		.b(opnd_b),
		.result(result),
		.flags_out(alu_flags)
	);

	assign next_flags = (alu_flags & ctrl.flag_mask) | (flags & ~ctrl.flag_mask);

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= next_flags;
	end

	assign rf.wr_sel = ctrl.rf_sel;
	assign rf.wr_data = result;
	assign rf.wr_en = ctrl.rf_en;

	assign dwrite_addr = inst.operand;
	assign dwrite_data = result;
	assign dwrite_en = reset ? 2'b00 : ctrl.mem_en;
	assign trap = !reset && ctrl.trap;
endmodule

`default_nettype wire

// ==== f8_fetch_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "f8_defines.svh"

module f8_fetch_stage
	import f8_pkg::*;
(
	input logic clk,
	input logic reset,
	input f8_inst_t iread_data,
	input f8_flags_t next_flags,
	f8_regfile_if.peek rf,
	output f8_word_t iread_addr,
	output f8_word_t dread_addr,
	output f8_inst_t inst
);
	// address of the instruction on iread_data
	f8_word_t pc;
	f8_word_t next_pc;
	f8_word_t jr_target;
	logic jr_taken;

	assign jr_target = pc + {{8{iread_data.operand[7]}}, iread_data.operand[7:0]};

	// flags come forwarded from the executing instruction
	always_comb
	begin
		case (iread_data.opcode)
			OP_JR: jr_taken = 1'b1;
			OP_JRZ: jr_taken = next_flags.z;
			OP_JRNZ: jr_taken = !next_flags.z;
			OP_JRC: jr_taken = next_flags.c;
			default: jr_taken = 1'b0;
		endcase
	end

	always_comb
	begin
		if (reset)
			next_pc = `F8_RESET_PC;
		else if (iread_data.opcode == OP_JP_IMM)
			next_pc = iread_data.operand;
		else if (iread_data.opcode == OP_JP_Y)
			next_pc = rf.next_y;
		else if (jr_taken)
			next_pc = jr_target;
		else
			next_pc = pc + f8_word_t'(f8_inst_len(iread_data.opcode));
	end

	assign iread_addr = next_pc;

	// data arrives in the cycle this instruction executes
	assign dread_addr = (iread_data.opcode == OP_ADD_XL_DIR || iread_data.opcode == OP_LDW_Y_DIR)
		? iread_data.operand : '0;

	always_ff @(posedge clk)
	begin
		pc <= next_pc;
		if (reset)
			inst <= '{operand: '0, opcode: OP_NOP};
		else
			inst <= iread_data;
	end
endmodule

`default_nettype wire

// ==== f8_pkg.sv ====
`default_nettype none

`include "f8_defines.svh"

package f8_pkg;

	typedef logic [`F8_WORD_W-1:0] f8_word_t;
	typedef logic [1:0] f8_bytesel_t;

	typedef enum logic [7:0] {
		OP_NOP = 8'h00,
		OP_TRAP = 8'h01,
		OP_INCW_Y = 8'h0c,
		OP_JP_Y = 8'h0f,
		OP_SUB_XL_IMM = 8'h10,
		OP_ADD_XL_IMM = 8'h18,
		OP_ADD_XL_DIR = 8'h19,
		OP_OR_XL_IMM = 8'h28,
		OP_AND_XL_IMM = 8'h30,
		OP_XOR_XL_IMM = 8'h38,
		OP_LD_XL_IMM = 8'h40,
		OP_LD_DIR_XL = 8'h48,
		OP_LDW_Y_IMM = 8'h60,
		OP_LDW_Y_DIR = 8'h61,
		OP_LDW_DIR_Y = 8'h68,
		OP_JP_IMM = 8'h80,
		OP_JR = 8'h90,
		OP_JRZ = 8'h92,
		OP_JRNZ = 8'h93,
		OP_JRC = 8'h94
	} f8_opcode_t;

	// byte 0 is the opcode, bytes 1 and 2 the little-endian operand
	typedef struct packed {
		logic [`F8_INST_W-9:0] operand;
		f8_opcode_t opcode;
	} f8_inst_t;

	typedef enum logic [3:0] {
		ALU_PASS_B,
		ALU_PASS_W,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_INCW
	} f8_alu_op_t;

	typedef enum logic [1:0] {
		B_IMM8,
		B_IMM16,
		B_DATA8,
		B_DATA16
	} f8_bsrc_t;

	typedef enum logic [1:0] {
		REG_X,
		REG_Y,
		REG_Z
	} f8_reg_t;

	typedef struct packed {
		logic c;
		logic z;
		logic n;
	} f8_flags_t;

	typedef struct packed {
		f8_alu_op_t alu_op;
		f8_bsrc_t b_src;
		f8_reg_t rf_sel;
		f8_bytesel_t rf_en;
		f8_bytesel_t mem_en;
		f8_flags_t flag_mask;
		logic trap;
	} f8_ctrl_t;

	function automatic logic [`F8_LEN_W-1:0] f8_inst_len(f8_opcode_t op);
		case (op)
			OP_LDW_Y_IMM, OP_ADD_XL_DIR, OP_LD_DIR_XL, OP_LDW_DIR_Y, OP_LDW_Y_DIR, OP_JP_IMM:
				return 2'd3;
			OP_LD_XL_IMM, OP_ADD_XL_IMM, OP_SUB_XL_IMM, OP_AND_XL_IMM, OP_OR_XL_IMM,
			OP_XOR_XL_IMM, OP_JR, OP_JRZ, OP_JRNZ, OP_JRC:
				return 2'd2;
			// unknown codes step like nop
			default:
				return 2'd1;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== f8_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module f8_regfile
	import f8_pkg::*;
(
	input logic clk,
	f8_regfile_if.store rf
);
	f8_word_t regs [3];
	f8_word_t next_regs [3];

	always_comb
	begin
		for (int i = 0; i < 3; i++)
		begin
			next_regs[i] = regs[i];
			if (rf.wr_sel == f8_reg_t'(i))
			begin
				if (rf.wr_en[0])
					next_regs[i][7:0] = rf.wr_data[7:0];
				if (rf.wr_en[1])
					next_regs[i][15:8] = rf.wr_data[15:8];
			end
		end
	end

	always_ff @(posedge clk)
		regs <= next_regs;

	assign rf.x = regs[0];
	assign rf.y = regs[1];
	assign rf.z = regs[2];

	// forwarded values for the instruction being decoded
	assign rf.next_x = next_regs[0];
	assign rf.next_y = next_regs[1];
	assign rf.next_z = next_regs[2];
endmodule

`default_nettype wire

// ==== f8_regfile_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface f8_regfile_if
	import f8_pkg::*;
();
	f8_word_t x;
	f8_word_t y;
	f8_word_t z;
	f8_word_t next_x;
	f8_word_t next_y;
	f8_word_t next_z;
	f8_reg_t wr_sel;
	f8_word_t wr_data;
	f8_bytesel_t wr_en;

	modport store (
		output x, y, z, next_x, next_y, next_z,
		input wr_sel, wr_data, wr_en
	);
	modport exec (
		output wr_sel, wr_data, wr_en,
		input x, y, z
	);
	// decode side looks one instruction ahead
	modport peek (input next_x, next_y, next_z);
endinterface

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_f8_core -o tb_f8_core
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_f8_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
	exit 0
fi
exit 1

// ==== sim.f ====
+incdir+.
f8_pkg.sv
f8_regfile_if.sv
f8_regfile.sv
f8_alu.sv
f8_decoder.sv
f8_fetch_stage.sv
f8_execute_stage.sv
f8_core.sv
f8_asserts.sv
tb_f8_core.sv

// ==== tb_f8_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "f8_defines.svh"

module tb_f8_core
	import f8_pkg::*;
();
	localparam int NUM_TESTS = 24;
	localparam int MAX_STEPS = 200;
	localparam longint WATCHDOG_NS = (NUM_TESTS * MAX_STEPS + 16) * 40;

	logic clk;
	logic reset;
	f8_inst_t iread_data;
	f8_word_t dread_data;
	f8_word_t iread_addr;
	f8_word_t dread_addr;
	f8_word_t dwrite_addr;
	f8_word_t dwrite_data;
	f8_bytesel_t dwrite_en;
	logic trap;

	logic [7:0] imem [65536];
	logic [7:0] dmem [65536];
	logic [7:0] m_dmem [65536];
	f8_word_t iaddr_q;
	f8_word_t daddr_q;
	f8_word_t cursor;

	// model registers carry over from test to test, like the core's
	f8_word_t m_x;
	f8_word_t m_y;
	f8_word_t exp_addr [$];
	f8_word_t exp_data [$];
	f8_bytesel_t exp_en [$];
	f8_word_t exp_raddr [$];

	logic active;
	logic exp_trap_left;
	int trap_count;
	int test_errors;
	int total_errors;
	int checks;
	int tests_run;

	f8_core i_dut (
		.clk(clk),
		.reset(reset),
		.iread_data(iread_data),
		.dread_data(dread_data),
		.iread_addr(iread_addr),
		.dread_addr(dread_addr),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en),
		.trap(trap)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// memories: address taken on the rising edge, data driven on the falling one
	always @(posedge clk)
	begin
		if (dwrite_en[0])
			dmem[dwrite_addr] <= dwrite_data[7:0];
		if (dwrite_en[1])
			dmem[dwrite_addr + 16'd1] <= dwrite_data[15:8];
		iaddr_q <= iread_addr;
		daddr_q <= dread_addr;
	end

	always @(negedge clk)
	begin
		iread_data <= {imem[iaddr_q + 16'd2], imem[iaddr_q + 16'd1], imem[iaddr_q]};
		dread_data <= {dmem[daddr_q + 16'd1], dmem[daddr_q]};
	end

	function automatic int inst_bytes(logic [7:0] ob);
		case (ob)
			OP_LDW_Y_IMM, OP_ADD_XL_DIR, OP_LD_DIR_XL, OP_LDW_DIR_Y, OP_LDW_Y_DIR, OP_JP_IMM:
				return 3;
			OP_LD_XL_IMM, OP_ADD_XL_IMM, OP_SUB_XL_IMM, OP_AND_XL_IMM, OP_OR_XL_IMM,
			OP_XOR_XL_IMM, OP_JR, OP_JRZ, OP_JRNZ, OP_JRC:
				return 2;
			default:
				return 1;
		endcase
	endfunction

	// instruction-level model, fills the expected write queues up to trap
	function automatic logic run_model();
		f8_word_t pc;
		f8_word_t npc;
		f8_word_t opr;
		logic [7:0] ob;
		logic [7:0] b;
		logic [8:0] t;
		logic [16:0] w;
		logic c;
		logic z;
		logic n;
		pc = `F8_RESET_PC;
		c = 1'b0;
		z = 1'b0;
		n = 1'b0;
		for (int step = 0; step < MAX_STEPS; step++)
		begin
			ob = imem[pc];
			opr = {imem[pc + 16'd2], imem[pc + 16'd1]};
			npc = pc + 16'(inst_bytes(ob));
			b = (ob == OP_ADD_XL_DIR) ? m_dmem[opr] : opr[7:0];
			if (ob == OP_ADD_XL_DIR || ob == OP_LDW_Y_DIR)
				exp_raddr.push_back(opr);
			case (ob)
				OP_LD_XL_IMM:
					m_x[7:0] = b;
				OP_LDW_Y_IMM:
					m_y = opr;
				OP_ADD_XL_IMM, OP_ADD_XL_DIR, OP_SUB_XL_IMM:
				begin
					if (ob == OP_SUB_XL_IMM)
						t = {1'b0, m_x[7:0]} - {1'b0, b};
					else
						t = {1'b0, m_x[7:0]} + {1'b0, b};
					m_x[7:0] = t[7:0];
					c = t[8];
					z = (t[7:0] == 8'h00);
					n = t[7];
				end
				OP_AND_XL_IMM, OP_OR_XL_IMM, OP_XOR_XL_IMM:
				begin
					if (ob == OP_AND_XL_IMM)
						m_x[7:0] = m_x[7:0] & b;
					else if (ob == OP_OR_XL_IMM)
						m_x[7:0] = m_x[7:0] | b;
					else
						m_x[7:0] = m_x[7:0] ^ b;
					z = (m_x[7:0] == 8'h00);
					n = m_x[7];
				end
				OP_INCW_Y:
				begin
					w = {1'b0, m_y} + 17'd1;
					m_y = w[15:0];
					c = w[16];
					z = (m_y == 16'h0000);
					n = m_y[15];
				end
				OP_LDW_Y_DIR:
					m_y = {m_dmem[opr + 16'd1], m_dmem[opr]};
				OP_LD_DIR_XL:
				begin
					m_dmem[opr] = m_x[7:0];
					exp_addr.push_back(opr);
					exp_data.push_back({8'h00, m_x[7:0]});
					exp_en.push_back(2'b01);
				end
				OP_LDW_DIR_Y:
				begin
					m_dmem[opr] = m_y[7:0];
					m_dmem[opr + 16'd1] = m_y[15:8];
					exp_addr.push_back(opr);
					exp_data.push_back(m_y);
					exp_en.push_back(2'b11);
				end
				OP_JR, OP_JRZ, OP_JRNZ, OP_JRC:
				begin
					if (ob == OP_JR || (ob == OP_JRZ && z) || (ob == OP_JRNZ && !z)
						|| (ob == OP_JRC && c))
						npc = pc + {{8{opr[7]}}, opr[7:0]};
				end
				OP_JP_IMM:
					npc = opr;
				OP_JP_Y:
					npc = m_y;
				OP_TRAP:
					return 1'b1;
				default: ;
			endcase
			pc = npc;
		end
		return 1'b0;
	endfunction

	task automatic check_word(string sig, f8_word_t exp, f8_word_t act);
		checks++;
		if (act !== exp)
		begin
			$display("[FAIL] %s: expected %h, got %h", sig, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_bytesel(string sig, f8_bytesel_t exp, f8_bytesel_t act);
		checks++;
		if (act !== exp)
		begin
			$display("[FAIL] %s: expected %h, got %h", sig, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_trap(logic exp, logic act);
		checks++;
		if (act !== exp)
		begin
			$display("[FAIL] trap: expected %h, got %h", exp, act);
			test_errors++;
		end
	endtask

	task automatic report(string msg);
		$display("error: %s", msg);
		test_errors++;
	endtask

	// compares every data read, write and trap with the model in order
	always @(posedge clk)
	begin
		if (reset)
		begin
			if (dwrite_en !== 2'b00 || trap !== 1'b0)
				report("memory write or trap while reset is high");
		end
		else if (active)
		begin
			// read address comes from the instruction being decoded
			if (iread_data.opcode == OP_ADD_XL_DIR || iread_data.opcode == OP_LDW_Y_DIR)
			begin
				if (exp_raddr.size() == 0)
					report("core decoded a data read the model does not expect");
				else
					check_word("dread_addr", exp_raddr.pop_front(), dread_addr);
			end
			if (dwrite_en != 2'b00)
			begin
				if (exp_addr.size() == 0)
					report("core made a write the model does not expect");
				else
				begin
					check_word("dwrite_addr", exp_addr.pop_front(), dwrite_addr);
					check_word("dwrite_data", exp_data.pop_front(), dwrite_data);
					check_bytesel("dwrite_en", exp_en.pop_front(), dwrite_en);
				end
			end
			if (trap)
			begin
				trap_count++;
				check_trap(exp_trap_left, trap);
				exp_trap_left = 1'b0;
				if (exp_addr.size() != 0)
					report("trap came before all expected writes");
			end
		end
	end

	task automatic start_test();
		@(negedge clk);
		reset = 1'b1;
		active = 1'b0;
		for (int a = 0; a < 65536; a++)
			imem[a] = 8'h00;
		cursor = `F8_RESET_PC;
	endtask

	task automatic emit(f8_opcode_t op, f8_word_t opr);
		int len;
		len = inst_bytes(op);
		imem[cursor] = op;
		if (len > 1)
			imem[cursor + 16'd1] = opr[7:0];
		if (len > 2)
			imem[cursor + 16'd2] = opr[15:8];
		cursor = cursor + 16'(len);
	endtask

	task automatic run_test(string name);
		int cycles;
		for (int a = 0; a < 65536; a++)
		begin
			dmem[a] = 8'((a ^ (a >> 8)) ^ 32'h3c);
			m_dmem[a] = dmem[a];
		end
		exp_addr.delete();
		exp_data.delete();
		exp_en.delete();
		exp_raddr.delete();
		exp_trap_left = run_model();
		test_errors = 0;
		trap_count = 0;
		active = 1'b1;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		cycles = 0;
		while (trap_count == 0 && cycles < MAX_STEPS)
		begin
			@(negedge clk);
			cycles++;
		end
		repeat (3) @(negedge clk);
		if (trap_count == 0)
			report("no trap within the cycle limit");
		if (exp_addr.size() != 0)
			report("expected writes never happened");
		if (exp_raddr.size() != 0)
			report("expected data reads never happened");
		active = 1'b0;
		tests_run++;
		total_errors += test_errors;
		$display("test %-10s %s, %0d errors", name, (test_errors == 0) ? "ok" : "bad", test_errors);
	endtask

	task automatic gen_random();
		f8_opcode_t pool [14] = '{OP_NOP, OP_LD_XL_IMM, OP_ADD_XL_IMM, OP_SUB_XL_IMM,
			OP_AND_XL_IMM, OP_OR_XL_IMM, OP_XOR_XL_IMM, OP_ADD_XL_DIR, OP_LD_DIR_XL,
			OP_LDW_DIR_Y, OP_LDW_Y_DIR, OP_INCW_Y, OP_JRZ, OP_JRC};
		f8_opcode_t ops [23];
		f8_word_t oprs [23];
		int skip;
		int d;
		ops[0] = OP_LD_XL_IMM;
		oprs[0] = 16'($urandom);
		ops[1] = OP_LDW_Y_IMM;
		oprs[1] = 16'($urandom);
		ops[22] = OP_TRAP;
		oprs[22] = 16'h0000;
		for (int i = 2; i < 22; i++)
		begin
			ops[i] = pool[int'($urandom % 14)];
			if ($urandom % 4 == 0)
				ops[i] = (($urandom % 2) == 0) ? OP_JRNZ : OP_JR;
			if (inst_bytes(ops[i]) == 3)
				oprs[i] = 16'h0100 + 16'($urandom % 16);
			else
				oprs[i] = 16'($urandom);
		end
		// forward branches land on an instruction boundary
		for (int i = 2; i < 22; i++)
		begin
			if (ops[i] == OP_JR || ops[i] == OP_JRZ || ops[i] == OP_JRNZ || ops[i] == OP_JRC)
			begin
				skip = int'($urandom % 4);
				if (skip > 21 - i)
					skip = 21 - i;
				d = 2;
				for (int j = i + 1; j <= i + skip; j++)
					d += inst_bytes(ops[j]);
				oprs[i] = {8'h00, 8'(d)};
			end
		end
		for (int i = 0; i < 23; i++)
			emit(ops[i], oprs[i]);
	endtask

	initial
	begin
		reset = 1'b1;
		iread_data = '0;
		dread_data = '0;
		active = 1'b0;
		m_x = '0;
		m_y = '0;
		tests_run = 0;
		total_errors = 0;
		checks = 0;
		void'($urandom(82053));

		start_test();
		emit(OP_LD_XL_IMM, 16'h003c);
		emit(OP_LD_DIR_XL, 16'h0300);
		emit(OP_ADD_XL_IMM, 16'h00d0);
		emit(OP_LD_DIR_XL, 16'h0301);
		emit(OP_SUB_XL_IMM, 16'h0020);
		emit(OP_LD_DIR_XL, 16'h0302);
		emit(OP_AND_XL_IMM, 16'h00f0);
		emit(OP_LD_DIR_XL, 16'h0303);
		emit(OP_OR_XL_IMM, 16'h0005);
		emit(OP_LD_DIR_XL, 16'h0304);
		emit(OP_XOR_XL_IMM, 16'h00ff);
		emit(OP_LD_DIR_XL, 16'h0305);
		emit(OP_LDW_Y_IMM, 16'ha55a);
		emit(OP_LDW_DIR_Y, 16'h0310);
		emit(OP_TRAP, 16'h0000);
		run_test("alu_imm");

		// store first, y kept from the test before
		start_test();
		emit(OP_LDW_DIR_Y, 16'h0320);
		emit(OP_LD_DIR_XL, 16'h0322);
		emit(OP_TRAP, 16'h0000);
		run_test("reset");

		start_test();
		emit(OP_LDW_Y_DIR, 16'h0120);
		emit(OP_INCW_Y, 16'h0000);
		emit(OP_LDW_DIR_Y, 16'h0122);
		emit(OP_LDW_Y_DIR, 16'h0122);
		emit(OP_INCW_Y, 16'h0000);
		emit(OP_LDW_DIR_Y, 16'h0124);
		emit(OP_LD_XL_IMM, 16'h0005);
		emit(OP_LD_DIR_XL, 16'h0130);
		emit(OP_ADD_XL_DIR, 16'h0130);
		emit(OP_LD_DIR_XL, 16'h0132);
		emit(OP_TRAP, 16'h0000);
		run_test("memory");

		start_test();
		emit(OP_LD_XL_IMM, 16'h0000);
		emit(OP_OR_XL_IMM, 16'h0000);
		emit(OP_JRZ, 16'h0005);
		emit(OP_LD_DIR_XL, 16'h0200);
		emit(OP_LD_DIR_XL, 16'h0201);
		emit(OP_JRNZ, 16'h0005);
		emit(OP_LD_DIR_XL, 16'h0202);
		emit(OP_SUB_XL_IMM, 16'h0001);
		emit(OP_JRC, 16'h0005);
		emit(OP_LD_DIR_XL, 16'h0203);
		emit(OP_JRNZ, 16'h0005);
		emit(OP_LD_DIR_XL, 16'h0204);
		emit(OP_ADD_XL_IMM, 16'h0001);
		emit(OP_JRNZ, 16'h0005);
		emit(OP_LD_DIR_XL, 16'h0205);
		emit(OP_LDW_Y_IMM, 16'h4100);
		emit(OP_JP_Y, 16'h0000);
		emit(OP_LD_DIR_XL, 16'h0206);
		cursor = 16'h4100;
		emit(OP_LD_DIR_XL, 16'h0207);
		emit(OP_JP_IMM, 16'h4180);
		emit(OP_LD_DIR_XL, 16'h0208);
		cursor = 16'h4180;
		emit(OP_TRAP, 16'h0000);
		run_test("branches");

		for (int r = 0; r < 20; r++)
		begin
			start_test();
			gen_random();
			run_test($sformatf("random_%0d", r));
		end

		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, total_errors);
		if (total_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired before all tests finished");
		$display("sim failed");
		$finish;
	end
endmodule

`default_nettype wire
